//--- hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

	localparam int DATA_BITS = 16;
	localparam int SEQ_BITS = 8;
	localparam int SHIFT_BITS = 4;         // Low bits of b used as shift amount

	typedef logic [DATA_BITS-1:0] data_t;
	typedef logic [SEQ_BITS-1:0] seq_t;
	typedef logic [2:0] func_t;

	// Codes 4'h8 and up are illegal
	typedef enum logic [3:0]
	{
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR = 4'h3,
		XOR = 4'h4,
		SHL = 4'h5,
		SHR = 4'h6,
		PASS = 4'h7
	} opcode_e;

	// ALU function selects, SUB runs on the adder
	localparam func_t FN_ADD = 3'd0;
	localparam func_t FN_AND = 3'd1;
	localparam func_t FN_OR = 3'd2;
	localparam func_t FN_XOR = 3'd3;
	localparam func_t FN_SHL = 3'd4;
	localparam func_t FN_SHR = 3'd5;
	localparam func_t FN_PASS = 3'd6;

	typedef struct packed
	{
		opcode_e opcode;
		data_t a;
		data_t b;
	} cmd_t;                               // 36 bits

	typedef struct packed
	{
		func_t func;
		logic invert_b;
		logic carry_in;
		logic illegal;
		data_t a;
		data_t b;
		logic valid;
	} ctrl_t;

	typedef struct packed
	{
		seq_t seq;
		data_t value;
		logic carry;
		logic zero;
		logic illegal;
	} res_t;                               // 27 bits

endpackage

`default_nettype wire

//--- hw/queue_pkg.sv
`default_nettype none

package queue_pkg;

	// Command queue, 4 entries
	localparam int CMD_ADDR_W = 2;

	// Result queue, 8 entries
	localparam int RES_ADDR_W = 3;

	// Almost-empty when count <= margin, almost-full when free slots <= margin.
	// Three covers the items in flight between decode and the result queue.
	localparam int ALMOST_MARGIN = 3;

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
#(
	parameter int ADDR_W = 2,
	parameter int DATA_W = 8
)
(
	input wire i_CLK,
	input wire i_RESET,
	input wire i_write_request,
	input wire i_read_request,
	input wire [DATA_W-1:0] i_data,
	output logic [DATA_W-1:0] o_data,
	output logic o_read_valid,
	output logic o_empty,
	output logic o_full,
	output logic o_almost_empty,
	output logic o_almost_full
);
	import queue_pkg::*;

	localparam int DEPTH = 2**ADDR_W;

	logic [DATA_W-1:0] mem [DEPTH];
	logic [ADDR_W-1:0] wr_ptr;
	logic [ADDR_W-1:0] rd_ptr;
	logic [ADDR_W:0] count;                // Extra bit so DEPTH fits
	logic [ADDR_W:0] count_next;
	logic wr_ok;
	logic rd_ok;

	assign wr_ok = i_write_request && !o_full;
	assign rd_ok = i_read_request && !o_empty;

	always_comb
	begin
		case ({wr_ok, rd_ok})
			2'b10: count_next = count + 1'b1;
			2'b01: count_next = count - 1'b1;
			default: count_next = count;   // Idle, or read and write together
		endcase
	end

	always_ff @(posedge i_CLK)
	begin
		if (wr_ok)
			mem[wr_ptr] <= i_data;
		if (rd_ok)
			o_data <= mem[rd_ptr];         // Registered output word
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_read_valid <= 1'b0;
			o_empty <= 1'b1;
			o_full <= 1'b0;
			o_almost_empty <= 1'b1;
			o_almost_full <= 1'b0;
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			o_read_valid <= rd_ok;
			// Flags follow the new count
			o_empty <= (count_next == '0);
			o_full <= (count_next == (ADDR_W+1)'(DEPTH));
			o_almost_empty <= (int'(count_next) <= ALMOST_MARGIN);
			o_almost_full <= ((DEPTH - int'(count_next)) <= ALMOST_MARGIN);
		end
	end

endmodule

`default_nettype wire

//--- hw/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode
(
	input wire i_CLK,
	input wire i_RESET,
	input wire alu_pkg::cmd_t i_cmd,
	input wire i_cmd_valid,
	input wire i_res_almost_full,
	output logic o_cmd_read,
	output alu_pkg::ctrl_t o_ctrl
);
	import alu_pkg::*;

	ctrl_t ctrl_next;

	// Keep popping while the result queue has room
	assign o_cmd_read = !i_res_almost_full;

	always_comb
	begin
		ctrl_next = '0;
		ctrl_next.a = i_cmd.a;
		ctrl_next.b = i_cmd.b;
		ctrl_next.valid = i_cmd_valid;
		case (i_cmd.opcode)
			ADD: ctrl_next.func = FN_ADD;
			SUB:
			begin
				ctrl_next.func = FN_ADD;   // a + ~b + 1
				ctrl_next.invert_b = 1'b1;
				ctrl_next.carry_in = 1'b1;
			end
			AND: ctrl_next.func = FN_AND;
			OR: ctrl_next.func = FN_OR;
			XOR: ctrl_next.func = FN_XOR;
			SHL: ctrl_next.func = FN_SHL;
			SHR: ctrl_next.func = FN_SHR;
			PASS: ctrl_next.func = FN_PASS;
			default: ctrl_next.illegal = 1'b1;
		endcase
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
			o_ctrl <= '0;
		else
			o_ctrl <= ctrl_next;           // Valid for one cycle per pop
	end

endmodule

`default_nettype wire

//--- hw/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute
(
	input wire i_CLK,
	input wire i_RESET,
	input wire alu_pkg::ctrl_t i_ctrl,
	output logic o_res_valid,
	output alu_pkg::data_t o_value,
	output logic o_carry,
	output logic o_zero,
	output logic o_illegal
);
	import alu_pkg::*;

	logic [DATA_BITS:0] sum;
	logic [SHIFT_BITS-1:0] shamt;
	data_t b_op;
	data_t value;
	logic carry;

	always_comb
	begin
		b_op = i_ctrl.invert_b ? ~i_ctrl.b : i_ctrl.b;
		sum = {1'b0, i_ctrl.a} + {1'b0, b_op} + (DATA_BITS+1)'(i_ctrl.carry_in);
		shamt = i_ctrl.b[SHIFT_BITS-1:0];
		carry = 1'b0;
		case (i_ctrl.func)
			FN_ADD:
			begin
				value = sum[DATA_BITS-1:0];
				carry = sum[DATA_BITS];    // On SUB, set when no borrow
			end
			FN_AND: value = i_ctrl.a & i_ctrl.b;
			FN_OR: value = i_ctrl.a | i_ctrl.b;
			FN_XOR: value = i_ctrl.a ^ i_ctrl.b;
			FN_SHL: value = i_ctrl.a << shamt;
			FN_SHR: value = i_ctrl.a >> shamt;   // Logical
			FN_PASS: value = i_ctrl.a;
			default: value = '0;
		endcase
		if (i_ctrl.illegal)
		begin
			value = '0;
			carry = 1'b0;
		end
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
			o_res_valid <= 1'b0;
		else
			o_res_valid <= i_ctrl.valid;
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_ctrl.valid)
		begin
			o_value <= value;
			o_carry <= carry;
			o_zero <= (value == '0);
			o_illegal <= i_ctrl.illegal;
		end
	end

endmodule

`default_nettype wire

//--- hw/result_pack.sv
`timescale 1ns/1ps
`default_nettype none

module result_pack
(
	input wire i_CLK,
	input wire i_RESET,
	input wire i_res_valid,
	input wire alu_pkg::data_t i_value,
	input wire i_carry,
	input wire i_zero,
	input wire i_illegal,
	output logic o_write,
	output alu_pkg::res_t o_res
);
	import alu_pkg::*;

	seq_t seq;                             // Next number to hand out

	assign o_write = i_res_valid;

	always_comb
	begin
		o_res.seq = seq;
		o_res.value = i_value;
		o_res.carry = i_carry;
		o_res.zero = i_zero;
		o_res.illegal = i_illegal;
	end

	// Wraps at 256, lets the host spot gaps
	always_ff @(posedge i_CLK)
	begin
		if (i_RESET)
			seq <= '0;
		else if (i_res_valid)
			seq <= seq + 1'b1;
	end

endmodule

`default_nettype wire

//--- hw/alu_stream_engine.sv
`timescale 1ns/1ps
`default_nettype none

module alu_stream_engine
(
	input wire i_CLK,
	input wire i_RESET,
	input wire i_cmd_write,
	input wire alu_pkg::cmd_t i_cmd,
	output logic o_cmd_full,
	output logic o_cmd_almost_full,
	input wire i_res_read,
	output alu_pkg::res_t o_res,
	output logic o_res_valid,
	output logic o_res_empty,
	output logic o_res_almost_empty
);
	import alu_pkg::*;
	import queue_pkg::*;

	cmd_t cmd_q;
	logic cmd_valid;
	logic cmd_read;
	logic res_almost_full;
	ctrl_t ctrl;
	logic exe_valid;
	data_t exe_value;
	logic exe_carry;
	logic exe_zero;
	logic exe_illegal;
	logic res_write;
	res_t res_in;

	sync_fifo #(.ADDR_W(CMD_ADDR_W), .DATA_W($bits(cmd_t))) cmd_fifo0
	(
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_write_request(i_cmd_write),
		.i_read_request(cmd_read),
		.i_data(i_cmd),
		.o_data(cmd_q),
		.o_read_valid(cmd_valid),
		.o_empty(),                    // Read-valid covers emptiness
		.o_full(o_cmd_full),
		.o_almost_empty(),
		.o_almost_full(o_cmd_almost_full)
	);

	cmd_decode cmd_decode0
	(
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_cmd(cmd_q),
		.i_cmd_valid(cmd_valid),
		.i_res_almost_full(res_almost_full),
		.o_cmd_read(cmd_read),
		.o_ctrl(ctrl)
	);

	alu_execute alu_execute0
	(
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_ctrl(ctrl),
		.o_res_valid(exe_valid),
		.o_value(exe_value),
		.o_carry(exe_carry),
		.o_zero(exe_zero),
		.o_illegal(exe_illegal)
	);

	result_pack result_pack0
	(
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_res_valid(exe_valid),
		.i_value(exe_value),
		.i_carry(exe_carry),
		.i_zero(exe_zero),
		.i_illegal(exe_illegal),
		.o_write(res_write),
		.o_res(res_in)
	);

	// Margin keeps room for the three items in flight
	sync_fifo #(.ADDR_W(RES_ADDR_W), .DATA_W($bits(res_t))) res_fifo0
	(
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_write_request(res_write),
		.i_read_request(i_res_read),
		.i_data(res_in),
		.o_data(o_res),
		.o_read_valid(o_res_valid),
		.o_empty(o_res_empty),
		.o_full(),
		.o_almost_empty(o_res_almost_empty),
		.o_almost_full(res_almost_full)
	);

endmodule

`default_nettype wire

//--- test/alu_stream_engine_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module alu_stream_engine_assertions
#(
	parameter int ADDR_W = 2
)
(
	input wire i_CLK,
	input wire i_RESET,
	input wire i_write_request,
	input wire i_read_request,
	input wire [ADDR_W:0] i_count,
	input wire [ADDR_W-1:0] i_wr_ptr,
	input wire [ADDR_W-1:0] i_rd_ptr,
	input wire i_read_valid,
	input wire i_empty,
	input wire i_full,
	input wire i_almost_empty,
	input wire i_almost_full
);
	import queue_pkg::*;

	localparam int DEPTH = 2**ADDR_W;

	logic [ADDR_W-1:0] ptr_gap;
	int fill;                              // Occupancy seen from the pointers
	int fail_count = 0;

	assign ptr_gap = i_wr_ptr - i_rd_ptr;
	assign fill = i_full ? DEPTH : int'(ptr_gap);

	// Equal pointers mean empty or full, never both
	full_and_empty: assert property (@(posedge i_CLK) disable iff (i_RESET)
		!(i_full && i_empty) && ((i_full || i_empty) == (i_wr_ptr == i_rd_ptr)))
		else
		begin
			$error("FIFO empty or full flag disagrees with the pointers");
			fail_count++;
		end

	// Write into a full FIFO with no read must leave the count alone
	ignored_write: assert property (@(posedge i_CLK) disable iff (i_RESET)
		(i_write_request && i_full && !i_read_request) |=> (i_count == $past(i_count)))
		else
		begin
			$error("FIFO count moved on an ignored write");
			fail_count++;
		end

	read_valid_source: assert property (@(posedge i_CLK) disable iff (i_RESET)
		i_read_valid == ($past(i_read_request) && (i_rd_ptr != $past(i_rd_ptr))))
		else
		begin
			$error("FIFO read-valid does not match a read pointer step");
			fail_count++;
		end

	almost_flags: assert property (@(posedge i_CLK) disable iff (i_RESET)
		(int'(i_count) == fill) &&
		(i_almost_empty == (fill <= ALMOST_MARGIN)) &&
		(i_almost_full == ((DEPTH - fill) <= ALMOST_MARGIN)))
		else
		begin
			$error("FIFO count or almost flags disagree with the pointers");
			fail_count++;
		end

endmodule

`default_nettype wire

//--- test/alu_stream_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_stream_engine_tb;
	import alu_pkg::*;

	localparam int TABLE_LEN = 14;
	localparam int RANDOM_COUNT = 200;
	localparam int TIMEOUT_CYCLES = (TABLE_LEN + RANDOM_COUNT) * 20;

	logic i_CLK;
	logic i_RESET;
	logic i_cmd_write;
	cmd_t i_cmd;
	logic o_cmd_full;
	logic o_cmd_almost_full;
	logic i_res_read;
	res_t o_res;
	logic o_res_valid;
	logic o_res_empty;
	logic o_res_almost_empty;

	cmd_t tbl_cmd [TABLE_LEN];
	res_t tbl_res [TABLE_LEN];
	res_t exp_q [$];                       // Expected results in order
	seq_t next_seq;
	logic read_pending;
	integer seed;
	int cycles;
	int sent;
	cmd_t cmd;
	res_t want;
	logic acc;

	alu_stream_engine dut0
	(
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_cmd_write(i_cmd_write),
		.i_cmd(i_cmd),
		.o_cmd_full(o_cmd_full),
		.o_cmd_almost_full(o_cmd_almost_full),
		.i_res_read(i_res_read),
		.o_res(o_res),
		.o_res_valid(o_res_valid),
		.o_res_empty(o_res_empty),
		.o_res_almost_empty(o_res_almost_empty)
	);

	bind sync_fifo alu_stream_engine_assertions #(.ADDR_W(ADDR_W)) fifo_checks0
	(
		.i_CLK(i_CLK),
		.i_RESET(i_RESET),
		.i_write_request(i_write_request),
		.i_read_request(i_read_request),
		.i_count(count),
		.i_wr_ptr(wr_ptr),
		.i_rd_ptr(rd_ptr),
		.i_read_valid(o_read_valid),
		.i_empty(o_empty),
		.i_full(o_full),
		.i_almost_empty(o_almost_empty),
		.i_almost_full(o_almost_full)
	);

	initial
	begin
		i_CLK = 1'b0;
		forever #50 i_CLK = ~i_CLK;
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge i_CLK);
			cycles++;
		end
		$display("Timeout after %0d cycles with %0d results outstanding",
			cycles, exp_q.size());
		$display("Errors found");
		$fatal(1, "Simulation stopped");
	end

	task automatic check_res(input res_t got, input res_t exp);
		if (got !== exp)
		begin
			$display("Fail %0t: result got seq %0d value %h c%b z%b i%b", $time,
				got.seq, got.value, got.carry, got.zero, got.illegal);
			$display("Fail %0t: expected seq %0d value %h c%b z%b i%b", $time,
				exp.seq, exp.value, exp.carry, exp.zero, exp.illegal);
			$display("Errors found");
			$fatal(1, "Result mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("Errors found");
			$fatal(1, "Flag mismatch");
		end
	endtask

	task automatic poll_assertions();
		if (dut0.cmd_fifo0.fifo_checks0.fail_count != 0 ||
			dut0.res_fifo0.fifo_checks0.fail_count != 0)
		begin
			$display("A FIFO assertion failed before %0t", $time);
			$display("Errors found");
			$fatal(1, "Assertion failure");
		end
	endtask

	// Reference ALU with carry only for ADD and SUB
	function automatic res_t model_res(input cmd_t c);
		res_t r;
		r = '0;
		case (c.opcode)
			ADD:
			begin
				r.value = c.a + c.b;
				r.carry = (int'(c.a) + int'(c.b)) > 16'hffff;
			end
			SUB:
			begin
				r.value = c.a - c.b;
				r.carry = (c.a >= c.b);    // No borrow
			end
			AND: r.value = c.a & c.b;
			OR: r.value = c.a | c.b;
			XOR: r.value = c.a ^ c.b;
			SHL: r.value = c.a << c.b[SHIFT_BITS-1:0];
			SHR: r.value = c.a >> c.b[SHIFT_BITS-1:0];
			PASS: r.value = c.a;
			default: r.illegal = 1'b1;
		endcase
		r.zero = (r.value == 16'h0000);
		return r;
	endfunction

	task automatic add_entry(input int idx, input logic [3:0] op, input data_t a, input data_t b,
		input data_t value, input logic carry, input logic zero, input logic illegal);
		tbl_cmd[idx].opcode = opcode_e'(op);
		tbl_cmd[idx].a = a;
		tbl_cmd[idx].b = b;
		tbl_res[idx] = '{seq: '0, value: value, carry: carry, zero: zero, illegal: illegal};
	endtask

	task automatic load_table();
		add_entry(0, 4'h0, 16'h1234, 16'h0ff0, 16'h2224, 1'b0, 1'b0, 1'b0);
		add_entry(1, 4'h0, 16'hffff, 16'h0001, 16'h0000, 1'b1, 1'b1, 1'b0);
		add_entry(2, 4'h1, 16'h5000, 16'h1000, 16'h4000, 1'b1, 1'b0, 1'b0);
		add_entry(3, 4'h1, 16'h0001, 16'h0002, 16'hffff, 1'b0, 1'b0, 1'b0);
		add_entry(4, 4'h1, 16'h00aa, 16'h00aa, 16'h0000, 1'b1, 1'b1, 1'b0);
		add_entry(5, 4'h2, 16'hf0f0, 16'h3c3c, 16'h3030, 1'b0, 1'b0, 1'b0);
		add_entry(6, 4'h3, 16'hf000, 16'h000f, 16'hf00f, 1'b0, 1'b0, 1'b0);
		add_entry(7, 4'h4, 16'haaaa, 16'haaaa, 16'h0000, 1'b0, 1'b1, 1'b0);
		add_entry(8, 4'h5, 16'h0001, 16'h0013, 16'h0008, 1'b0, 1'b0, 1'b0);
		add_entry(9, 4'h6, 16'h8000, 16'h001f, 16'h0001, 1'b0, 1'b0, 1'b0);
		add_entry(10, 4'h7, 16'hbeef, 16'h1234, 16'hbeef, 1'b0, 1'b0, 1'b0);
		add_entry(11, 4'h9, 16'h1111, 16'h2222, 16'h0000, 1'b0, 1'b1, 1'b1);
		add_entry(12, 4'hf, 16'h0005, 16'h0003, 16'h0000, 1'b0, 1'b1, 1'b1);
		add_entry(13, 4'h0, 16'h8000, 16'h8000, 16'h0000, 1'b1, 1'b1, 1'b0);
	endtask

	task automatic rand_cmd(output cmd_t c, output res_t exp);
		logic [3:0] op;
		op = 4'($unsigned($random(seed)) % 9);   // Code 8 is illegal
		c.opcode = opcode_e'(op);
		c.a = data_t'($random(seed));
		c.b = data_t'($random(seed));
		exp = model_res(c);
	endtask

	task automatic collect_result();
		res_t exp;
		check_flag("o_res_valid", o_res_valid, read_pending);
		if (o_res_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("A result came out while none was outstanding at %0t", $time);
				$display("Errors found");
				$fatal(1, "Unexpected result");
			end
			exp = exp_q.pop_front();
			check_res(o_res, exp);
		end
	endtask

	// Sample outputs then drive the next inputs
	task automatic tick(input logic wr, input logic raw_wr, input cmd_t c, input res_t exp,
		input logic rd, output logic accepted);
		res_t w;
		@(posedge i_CLK);
		#5;
		collect_result();
		poll_assertions();
		accepted = wr && !o_cmd_full;
		i_cmd_write = wr && (raw_wr || !o_cmd_full);
		i_cmd = c;
		i_res_read = rd && !o_res_empty;
		read_pending = i_res_read;
		if (accepted)
		begin
			w = exp;
			w.seq = next_seq;
			exp_q.push_back(w);
			next_seq++;
		end
	endtask

	task automatic drain();
		logic a;
		while (exp_q.size() != 0)
			tick(1'b0, 1'b0, '0, '0, 1'b1, a);
	endtask

	initial
	begin
		seed = 32'hf05f_140e;
		i_RESET = 1'b1;
		i_cmd_write = 1'b0;
		i_cmd = '0;
		i_res_read = 1'b0;
		read_pending = 1'b0;
		next_seq = '0;
		load_table();
		repeat (4) @(posedge i_CLK);
		#5;
		i_RESET = 1'b0;
		check_flag("o_res_empty", o_res_empty, 1'b1);
		check_flag("o_res_almost_empty", o_res_almost_empty, 1'b1);
		check_flag("o_cmd_full", o_cmd_full, 1'b0);
		check_flag("o_cmd_almost_full", o_cmd_almost_full, 1'b0);
		check_flag("o_res_valid", o_res_valid, 1'b0);

		for (int i = 0; i < TABLE_LEN; i++)
		begin
			acc = 1'b0;
			while (!acc)
				tick(1'b1, 1'b0, tbl_cmd[i], tbl_res[i], 1'b1, acc);
		end
		drain();

		acc = 1'b1;                        // No reads until the command side fills
		while (acc)
		begin
			rand_cmd(cmd, want);
			tick(1'b1, 1'b1, cmd, want, 1'b0, acc);
		end
		repeat (3)
		begin
			rand_cmd(cmd, want);
			tick(1'b1, 1'b1, cmd, want, 1'b0, acc);
			check_flag("o_cmd_full", o_cmd_full, 1'b1);
			check_flag("o_cmd_almost_full", o_cmd_almost_full, 1'b1);
			check_flag("o_res_almost_empty", o_res_almost_empty, 1'b0);
		end
		drain();

		repeat (3)
		begin
			rand_cmd(cmd, want);
			tick(1'b1, 1'b0, cmd, want, 1'b0, acc);
		end
		while (o_res_empty)
			tick(1'b0, 1'b0, '0, '0, 1'b0, acc);
		repeat (8)
		begin
			rand_cmd(cmd, want);
			tick(1'b1, 1'b0, cmd, want, 1'b1, acc);   // Read and write together
		end
		drain();

		sent = 0;
		rand_cmd(cmd, want);
		while (sent < RANDOM_COUNT)
		begin
			tick(1'b1, 1'b0, cmd, want, 1'b1, acc);
			if (acc)
			begin
				sent++;
				rand_cmd(cmd, want);
			end
		end
		drain();

		repeat (4) tick(1'b0, 1'b0, '0, '0, 1'b0, acc);
		check_flag("o_res_empty", o_res_empty, 1'b1);
		poll_assertions();
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
hw/alu_pkg.sv
hw/queue_pkg.sv
hw/sync_fifo.sv
hw/cmd_decode.sv
hw/alu_execute.sv
hw/result_pack.sv
hw/alu_stream_engine.sv
test/alu_stream_engine_assertions.sv
test/alu_stream_engine_tb.sv
